//--- Bender.yml
package:
  name: mem_system

sources:
  - files:
      - hw/mem_sys_pkg.sv
      - hw/cache_way_if.sv
      - hw/mem_bus_if.sv
      - hw/cache_way.sv
      - hw/banked_memory.sv
      - hw/cache_controller.sv
      - hw/mem_system.sv

  - target: test
    files:
      - bench/clock_gen.sv
      - bench/tb_mem_system.sv

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk; // Half of the 4 ns period
		end
	end

endmodule

//--- bench/tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system;

	localparam int WAIT_LIMIT = 40; // Cycles, well above the longest miss

	logic clk;
	logic rst;
	logic [mem_sys_pkg::ADDR_W-1:0] addr;
	logic [mem_sys_pkg::DATA_W-1:0] data_in;
	logic rd;
	logic wr;
	logic [mem_sys_pkg::DATA_W-1:0] data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;

	logic [mem_sys_pkg::DATA_W-1:0] shadow [mem_sys_pkg::MEM_WORDS];
	logic [mem_sys_pkg::ADDR_W-1:0] cur_addr;
	logic [mem_sys_pkg::DATA_W-1:0] cur_exp; // Shadow word when the request went out
	logic cur_rd;
	logic started;
	logic timed_out;
	int exp_lat; // Zero allows any legal latency
	int cyc; // Cycles since the acceptance edge
	int errors;
	int first_error;
	int tests_run;
	int tests_bad;
	logic [31:0] rng;
	logic [mem_sys_pkg::TAG_W-1:0] tag_set [3];
	logic [mem_sys_pkg::INDEX_W-1:0] index_set [2];
	logic [mem_sys_pkg::ADDR_W-1:0] base_addr;
	logic [mem_sys_pkg::ADDR_W-1:0] evict_addr [3];
	logic [mem_sys_pkg::DATA_W-1:0] evict_data [3];

	clock_gen clk_src (.clk(clk));

	mem_system uut (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc <= 0;
		end else if ((rd || wr) && !stall) begin
			cyc <= 1; // Acceptance, also in a done cycle
		end else if (done) begin
			cyc <= 0;
		end else if (cyc != 0) begin
			cyc <= cyc + 1;
		end
	end

	a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
		!started |-> !done && !stall && !err && !cache_hit)
	else begin
		errors++;
		$display("An output went high before the first request");
	end

	a_no_done_in_stall: assert property (@(posedge clk) disable iff (rst) !(done && stall))
	else begin
		errors++;
		$display("done and stall were high in the same cycle");
	end

	// Busy from the compare cycle up to the done cycle
	a_stall_while_busy: assert property (@(posedge clk) disable iff (rst)
		cyc != 0 && !done |-> stall)
	else begin
		errors++;
		$display("** Error: stall = %h, expected %h (addr %h)",
			$sampled(stall), 1'b1, $sampled(cur_addr));
	end

	a_read_data: assert property (@(posedge clk) disable iff (rst)
		done && cur_rd && !cur_addr[0] |-> data_out == cur_exp)
	else begin
		errors++;
		$display("** Error: data_out = %h, expected %h (addr %h)",
			$sampled(data_out), $sampled(cur_exp), $sampled(cur_addr));
	end

	// Hit or odd address 1, clean miss 9, dirty miss 13
	a_latency: assert property (@(posedge clk) disable iff (rst)
		done |-> (exp_lat == 0) ? (cyc == 1 || cyc == 9 || cyc == 13) : (cyc == exp_lat))
	else begin
		errors++;
		$display("** Error: done latency = %h, expected %h (addr %h)",
			$sampled(cyc), $sampled(exp_lat), $sampled(cur_addr));
	end

	a_hit_flag: assert property (@(posedge clk) disable iff (rst)
		done |-> cache_hit == (!cur_addr[0] && cyc == 1))
	else begin
		errors++;
		$display("** Error: cache_hit = %h, expected %h (addr %h)",
			$sampled(cache_hit), $sampled(!cur_addr[0] && cyc == 1), $sampled(cur_addr));
	end

	a_err_flag: assert property (@(posedge clk) disable iff (rst) done |-> err == cur_addr[0])
	else begin
		errors++;
		$display("** Error: err = %h, expected %h (addr %h)",
			$sampled(err), $sampled(cur_addr[0]), $sampled(cur_addr));
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [mem_sys_pkg::ADDR_W-1:0] make_addr(
		input logic [mem_sys_pkg::TAG_W-1:0] tag,
		input logic [mem_sys_pkg::INDEX_W-1:0] index,
		input logic [1:0] word
	);
		return {tag, index, word, 1'b0};
	endfunction

	// Called at the drive point, one ns after a rising edge
	task automatic issue_request(
		input logic [mem_sys_pkg::ADDR_W-1:0] a,
		input logic is_wr,
		input logic [mem_sys_pkg::DATA_W-1:0] d,
		input int lat
	);
		int n;
		if (timed_out) return;
		cur_addr = a;
		cur_rd = !is_wr;
		cur_exp = shadow[a[mem_sys_pkg::ADDR_W-1:1]];
		exp_lat = lat;
		if (is_wr && !a[0]) begin
			shadow[a[mem_sys_pkg::ADDR_W-1:1]] = d; // Odd addresses change nothing
		end
		addr = a;
		data_in = d;
		rd = !is_wr;
		wr = is_wr;
		started = 1'b1;
		n = 0;
		while (stall && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (stall) begin
			$display("Timeout: the system never became idle for address %h", a);
			errors++;
			timed_out = 1'b1;
			return;
		end
		@(posedge clk); // Acceptance edge
		#1;
		rd = 1'b0;
		wr = 1'b0;
		n = 0;
		while (!done && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!done) begin
			$display("Timeout: no done for address %h, controller in state %s",
				a, uut.ctrl.state.name());
			errors++;
			timed_out = 1'b1;
			return;
		end
		@(posedge clk); // Let the checks sample the done cycle
		#1;
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == first_error) begin
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d error(s)", name, errors - first_error);
		end
		first_error = errors;
	endtask

	initial begin
		for (int i = 0; i < mem_sys_pkg::MEM_WORDS; i++) begin
			shadow[i] = '0;
		end
		rst = 1'b1;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		cur_addr = '0;
		cur_exp = '0;
		cur_rd = 1'b0;
		started = 1'b0;
		timed_out = 1'b0;
		exp_lat = 0;
		errors = 0;
		first_error = 0;
		tests_run = 0;
		tests_bad = 0;
		rng = 32'h6708;
		tag_set = '{5'd3, 5'd7, 5'd20};
		index_set = '{8'd10, 8'd40};
		base_addr = make_addr(5'd0, 8'd10, 2'd1);
		evict_data = '{16'hA003, 16'hB007, 16'hC014};
		for (int k = 0; k < 3; k++) begin
			evict_addr[k] = make_addr(tag_set[k], 8'd40, 2'd2);
		end
		for (int k = 0; k < 4; k++) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;

		for (int k = 0; k < 8; k++) begin
			@(posedge clk);
			#1;
		end
		report_test("1 reset state");

		issue_request(base_addr, 1'b0, 16'h0, 9); // Cold miss
		issue_request(base_addr, 1'b0, 16'h0, 1);
		report_test("2 cold read and reread");

		issue_request(base_addr, 1'b1, 16'h5A5A, 1);
		issue_request(base_addr, 1'b0, 16'h0, 1);
		report_test("3 write hit then read hit");

		issue_request(evict_addr[0], 1'b1, evict_data[0], 9);
		issue_request(evict_addr[1], 1'b1, evict_data[1], 9);
		issue_request(evict_addr[2], 1'b1, evict_data[2], 13); // Both ways dirty
		for (int k = 0; k < 3; k++) begin
			issue_request(evict_addr[k], 1'b0, 16'h0, 0);
		end
		report_test("4 dirty eviction and writeback");

		issue_request(base_addr | 16'h1, 1'b1, 16'hDEAD, 1);
		issue_request(base_addr | 16'h1, 1'b0, 16'h0, 1);
		issue_request(base_addr, 1'b0, 16'h0, 1);
		report_test("5 odd address");

		for (int i = 0; i < 200; i++) begin
			rng = xorshift(rng);
			issue_request(make_addr(tag_set[int'(rng[9:8]) % 3], index_set[rng[12]], rng[3:2]),
				rng[4], rng[31:16], 0);
		end
		report_test("6 random traffic");

		$display("Summary: %0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_bad, errors);
		if (errors == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- hw/banked_memory.sv
`timescale 1ns/1ps

module banked_memory (
	input logic clk,
	input logic rst,
	mem_bus_if.mem bus
);

	logic [mem_sys_pkg::DATA_W-1:0] bank_q [mem_sys_pkg::LINE_WORDS];
	logic [mem_sys_pkg::BANK_W-1:0] rd_bank_q;
	logic [mem_sys_pkg::DATA_W-1:0] data_pipe [mem_sys_pkg::MEM_LATENCY-1];
	logic [mem_sys_pkg::MEM_LATENCY-1:0] vld_pipe;

	for (genvar b = 0; b < mem_sys_pkg::LINE_WORDS; b++) begin : g_bank
		logic [mem_sys_pkg::DATA_W-1:0] ram [mem_sys_pkg::BANK_DEPTH];

		initial begin
			for (int i = 0; i < mem_sys_pkg::BANK_DEPTH; i++) begin
				ram[i] = '0;
			end
		end

		always_ff @(posedge clk) begin
			if (bus.wr && (bus.addr.mem.bank == mem_sys_pkg::BANK_W'(b))) begin
				ram[bus.addr.mem.block] <= bus.wdata;
			end
			if (bus.rd) begin
				bank_q[b] <= ram[bus.addr.mem.block]; // All banks read, one is kept
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.rd) begin
			rd_bank_q <= bus.addr.mem.bank;
		end
		data_pipe[0] <= bank_q[rd_bank_q];
		for (int i = 1; i < mem_sys_pkg::MEM_LATENCY - 1; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[mem_sys_pkg::MEM_LATENCY-2:0], bus.rd};
		end
	end

	assign bus.rdata = data_pipe[mem_sys_pkg::MEM_LATENCY-2];
	assign bus.rvalid = vld_pipe[mem_sys_pkg::MEM_LATENCY-1];

	// Writeback and refill never overlap on the bus
	a_rd_wr_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(bus.rd && bus.wr)
	) else $error("banked_memory: rd and wr high together");

endmodule

//--- hw/cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
	input logic clk,
	input logic rst,
	input logic [mem_sys_pkg::ADDR_W-1:0] addr,
	input logic [mem_sys_pkg::DATA_W-1:0] data_in,
	input logic rd,
	input logic wr,
	output logic [mem_sys_pkg::DATA_W-1:0] data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err,
	cache_way_if.ctrl way0,
	cache_way_if.ctrl way1,
	mem_bus_if.ctrl mem
);

	mem_sys_pkg::ctrl_state_e state, state_nxt;
	mem_sys_pkg::addr_u req_addr;
	mem_sys_pkg::addr_u mem_addr;
	mem_sys_pkg::offset_t way_offset;
	logic [mem_sys_pkg::DATA_W-1:0] req_data;
	logic req_wr;
	logic victim;
	logic fill_way; // Way picked in allocate
	logic choose_way;
	logic choose_dirty;
	logic hit0, hit1, any_hit, odd_addr, accept;
	logic in_compare, in_finish, is_wb, is_req, is_fill;
	logic en0, en1, write_cmd;
	logic [mem_sys_pkg::BANK_W-1:0] mem_word;
	logic [mem_sys_pkg::WORD_W-1:0] fill_word;
	logic [mem_sys_pkg::TAG_W-1:0] old_tag;

	assign in_compare = (state == mem_sys_pkg::s_compare);
	assign in_finish = (state == mem_sys_pkg::s_finish);
	assign is_wb = state inside {mem_sys_pkg::s_wb0, mem_sys_pkg::s_wb1,
		mem_sys_pkg::s_wb2, mem_sys_pkg::s_wb3};
	assign is_req = state inside {mem_sys_pkg::s_req0, mem_sys_pkg::s_req1,
		mem_sys_pkg::s_req2_fill0, mem_sys_pkg::s_req3_fill1};
	assign is_fill = state inside {mem_sys_pkg::s_req2_fill0, mem_sys_pkg::s_req3_fill1,
		mem_sys_pkg::s_fill2, mem_sys_pkg::s_fill3};

	assign hit0 = way0.hit & way0.valid;
	assign hit1 = way1.hit & way1.valid;
	assign any_hit = hit0 | hit1;
	assign odd_addr = req_addr.cache.offset.byte_bit;

	// Done cycles release stall, so a new request can be taken there
	assign done = (in_compare & (odd_addr | any_hit)) | in_finish;
	assign stall = (state != mem_sys_pkg::s_idle) & ~done;
	assign err = in_compare & odd_addr;
	assign cache_hit = in_compare & any_hit & ~odd_addr;
	assign accept = (rd | wr) & ~stall;

	// Invalid way first, then the victim bit
	assign choose_way = ~way0.valid ? 1'b0 : ~way1.valid ? 1'b1 : victim;
	assign choose_dirty = choose_way ? (way1.valid & way1.dirty) : (way0.valid & way0.dirty);
	assign old_tag = fill_way ? way1.tag_out : way0.tag_out;

	always_comb begin
		mem_word = 2'd0;
		fill_word = 2'd0;
		case (state)
			mem_sys_pkg::s_wb1, mem_sys_pkg::s_req1: mem_word = 2'd1;
			mem_sys_pkg::s_wb2: mem_word = 2'd2;
			mem_sys_pkg::s_wb3: mem_word = 2'd3;
			mem_sys_pkg::s_req2_fill0: mem_word = 2'd2;
			mem_sys_pkg::s_req3_fill1: begin
				mem_word = 2'd3;
				fill_word = 2'd1;
			end
			mem_sys_pkg::s_fill2: fill_word = 2'd2;
			mem_sys_pkg::s_fill3: fill_word = 2'd3;
			default: ;
		endcase
	end

	always_comb begin
		way_offset = req_addr.cache.offset;
		if (is_fill) begin
			way_offset.word = fill_word;
		end else if (is_wb) begin
			way_offset.word = mem_word; // Read the word being written back
		end
	end

	assign en0 = (in_compare & ~odd_addr) | ((is_fill | in_finish) & ~fill_way);
	assign en1 = (in_compare & ~odd_addr) | ((is_fill | in_finish) & fill_way);
	assign write_cmd = is_fill | ((in_compare | in_finish) & req_wr);

	assign way0.enable = en0;
	assign way0.comp = in_compare | in_finish;
	assign way0.write = write_cmd & en0;
	assign way0.index = req_addr.cache.index;
	assign way0.offset = way_offset;
	assign way0.tag_in = req_addr.cache.tag;
	assign way0.data_in = is_fill ? mem.rdata : req_data;

	assign way1.enable = en1;
	assign way1.comp = in_compare | in_finish;
	assign way1.write = write_cmd & en1;
	assign way1.index = req_addr.cache.index;
	assign way1.offset = way_offset;
	assign way1.tag_in = req_addr.cache.tag;
	assign way1.data_in = is_fill ? mem.rdata : req_data;

	always_comb begin
		mem_addr.mem.block = is_wb ? {old_tag, req_addr.cache.index}
			: {req_addr.cache.tag, req_addr.cache.index};
		mem_addr.mem.bank = mem_word;
		mem_addr.mem.byte_bit = 1'b0;
	end

	assign mem.rd = is_req;
	assign mem.wr = is_wb;
	assign mem.addr = mem_addr;
	assign mem.wdata = fill_way ? way1.data_out : way0.data_out;

	assign data_out = in_compare ? (hit0 ? way0.data_out : way1.data_out)
		: (fill_way ? way1.data_out : way0.data_out);

	always_comb begin
		state_nxt = state;
		case (state)
			mem_sys_pkg::s_idle: if (accept) state_nxt = mem_sys_pkg::s_compare;
			mem_sys_pkg::s_compare: begin
				if (!done) state_nxt = mem_sys_pkg::s_allocate;
				else state_nxt = accept ? mem_sys_pkg::s_compare : mem_sys_pkg::s_idle;
			end
			mem_sys_pkg::s_allocate: begin
				state_nxt = choose_dirty ? mem_sys_pkg::s_wb0 : mem_sys_pkg::s_req0;
			end
			mem_sys_pkg::s_wb0: state_nxt = mem_sys_pkg::s_wb1;
			mem_sys_pkg::s_wb1: state_nxt = mem_sys_pkg::s_wb2;
			mem_sys_pkg::s_wb2: state_nxt = mem_sys_pkg::s_wb3;
			mem_sys_pkg::s_wb3: state_nxt = mem_sys_pkg::s_req0;
			mem_sys_pkg::s_req0: state_nxt = mem_sys_pkg::s_req1;
			mem_sys_pkg::s_req1: state_nxt = mem_sys_pkg::s_req2_fill0;
			mem_sys_pkg::s_req2_fill0: state_nxt = mem_sys_pkg::s_req3_fill1;
			mem_sys_pkg::s_req3_fill1: state_nxt = mem_sys_pkg::s_fill2;
			mem_sys_pkg::s_fill2: state_nxt = mem_sys_pkg::s_fill3;
			mem_sys_pkg::s_fill3: state_nxt = mem_sys_pkg::s_finish;
			mem_sys_pkg::s_finish: begin
				state_nxt = accept ? mem_sys_pkg::s_compare : mem_sys_pkg::s_idle;
			end
			default: state_nxt = mem_sys_pkg::s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_sys_pkg::s_idle;
			victim <= 1'b0;
		end else begin
			state <= state_nxt;
			if (in_compare) victim <= ~victim; // Flips on every lookup
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= addr;
			req_data <= data_in;
			req_wr <= wr;
		end
		if (state == mem_sys_pkg::s_allocate) begin
			fill_way <= choose_way;
		end
	end

	a_single_kind: assert property (
		@(posedge clk) disable iff (rst)
		accept |-> !(rd && wr)
	) else $error("cache_controller: rd and wr both high at acceptance");

	a_legal_state: assert property (
		@(posedge clk) disable iff (rst)
		state inside {[mem_sys_pkg::s_idle : mem_sys_pkg::s_finish]}
	) else $error("cache_controller: illegal state %0d", state);

	// Refill data must line up with the fill states
	a_rvalid_in_fill: assert property (
		@(posedge clk) disable iff (rst)
		mem.rvalid |-> is_fill
	) else $error("cache_controller: rvalid outside fill, state %s", state.name());

endmodule

//--- hw/cache_way.sv
`timescale 1ns/1ps

module cache_way (
	input logic clk,
	input logic rst,
	cache_way_if.way port
);

	logic [mem_sys_pkg::TAG_W-1:0] line_tag [mem_sys_pkg::NUM_LINES];
	logic [mem_sys_pkg::DATA_W-1:0] line_data [mem_sys_pkg::NUM_LINES][mem_sys_pkg::LINE_WORDS];
	logic [mem_sys_pkg::NUM_LINES-1:0] line_valid;
	logic [mem_sys_pkg::NUM_LINES-1:0] line_dirty;

	logic tag_match;
	logic do_write;

	assign tag_match = (line_tag[port.index] == port.tag_in);

	// A compare write only lands on a valid matching line
	assign do_write = port.enable & port.write & (~port.comp | (tag_match & line_valid[port.index]));

	assign port.hit = tag_match;
	assign port.valid = line_valid[port.index];
	assign port.dirty = line_dirty[port.index];
	assign port.tag_out = line_tag[port.index];
	assign port.data_out = line_data[port.index][port.offset.word];

	always_ff @(posedge clk) begin
		if (do_write) begin
			line_data[port.index][port.offset.word] <= port.data_in;
			if (!port.comp) begin
				line_tag[port.index] <= port.tag_in; // Fill sets the new tag
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			line_valid <= '0;
			line_dirty <= '0;
		end else if (do_write) begin
			if (port.comp) begin
				line_dirty[port.index] <= 1'b1; // Write hit
			end else begin
				line_valid[port.index] <= 1'b1;
				line_dirty[port.index] <= 1'b0;
			end
		end
	end

	// The controller never asks a disabled way to write
	a_no_write_disabled: assert property (
		@(posedge clk) disable iff (rst)
		!port.enable |-> !port.write
	) else $error("cache_way: write requested while disabled");

endmodule

//--- hw/cache_way_if.sv
`timescale 1ns/1ps

interface cache_way_if;

	// Command, from the controller
	logic enable;
	logic comp;
	logic write;
	logic [mem_sys_pkg::INDEX_W-1:0] index;
	mem_sys_pkg::offset_t offset;
	logic [mem_sys_pkg::TAG_W-1:0] tag_in;
	logic [mem_sys_pkg::DATA_W-1:0] data_in;

	// Response, combinational on index and offset
	logic hit;
	logic valid;
	logic dirty;
	logic [mem_sys_pkg::TAG_W-1:0] tag_out;
	logic [mem_sys_pkg::DATA_W-1:0] data_out;

	modport ctrl (
		output enable, comp, write, index, offset, tag_in, data_in,
		input hit, valid, dirty, tag_out, data_out
	);

	modport way (
		input enable, comp, write, index, offset, tag_in, data_in,
		output hit, valid, dirty, tag_out, data_out
	);

endinterface

//--- hw/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

	logic rd;
	logic wr;
	mem_sys_pkg::addr_u addr; // Memory view used by the banks
	logic [mem_sys_pkg::DATA_W-1:0] wdata;

	logic [mem_sys_pkg::DATA_W-1:0] rdata;
	logic rvalid; // Fixed latency after rd

	modport ctrl (
		output rd, wr, addr, wdata,
		input rdata, rvalid
	);

	modport mem (
		input rd, wr, addr, wdata,
		output rdata, rvalid
	);

endinterface

//--- hw/mem_sys_pkg.sv
package mem_sys_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// Cache view of an address
	localparam int TAG_W = 5;
	localparam int INDEX_W = 8;
	localparam int OFFSET_W = 3;
	localparam int WORD_W = OFFSET_W - 1; // Word select inside a line
	localparam int NUM_LINES = 2 ** INDEX_W;

	// Memory view of an address
	localparam int LINE_WORDS = 4; // Also the bank count
	localparam int BANK_W = 2;
	localparam int BLOCK_W = TAG_W + INDEX_W;
	localparam int MEM_WORDS = 32768;
	localparam int BANK_DEPTH = MEM_WORDS / LINE_WORDS;
	localparam int MEM_LATENCY = 2; // Cycles from rd edge to rvalid

	typedef struct packed {
		logic [WORD_W-1:0] word;
		logic byte_bit;
	} offset_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		offset_t offset;
	} cache_view_t;

	typedef struct packed {
		logic [BLOCK_W-1:0] block;
		logic [BANK_W-1:0] bank; // Same bits as the word select
		logic byte_bit;
	} mem_view_t;

	typedef union packed {
		cache_view_t cache;
		mem_view_t mem;
	} addr_u;

	typedef enum logic [3:0] {
		s_idle = 4'd0,
		s_compare = 4'd1,
		s_allocate = 4'd2,
		s_wb0 = 4'd3,
		s_wb1 = 4'd4,
		s_wb2 = 4'd5,
		s_wb3 = 4'd6,
		s_req0 = 4'd7,
		s_req1 = 4'd8,
		s_req2_fill0 = 4'd9,
		s_req3_fill1 = 4'd10,
		s_fill2 = 4'd11,
		s_fill3 = 4'd12,
		s_finish = 4'd13
	} ctrl_state_e;

endpackage

//--- hw/mem_system.sv
`timescale 1ns/1ps

module mem_system (
	input logic clk,
	input logic rst,
	input logic [mem_sys_pkg::ADDR_W-1:0] addr,
	input logic [mem_sys_pkg::DATA_W-1:0] data_in,
	input logic rd,
	input logic wr,
	output logic [mem_sys_pkg::DATA_W-1:0] data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);

	cache_way_if way0_bus ();
	cache_way_if way1_bus ();
	mem_bus_if mem_bus ();

	cache_controller ctrl (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err),
		.way0(way0_bus.ctrl),
		.way1(way1_bus.ctrl),
		.mem(mem_bus.ctrl)
	);

	cache_way way0 (
		.clk(clk),
		.rst(rst),
		.port(way0_bus.way)
	);

	cache_way way1 (
		.clk(clk),
		.rst(rst),
		.port(way1_bus.way)
	);

	banked_memory mem (
		.clk(clk),
		.rst(rst),
		.bus(mem_bus.mem)
	);

endmodule

//--- mem_system.f
hw/mem_sys_pkg.sv
hw/cache_way_if.sv
hw/mem_bus_if.sv
hw/cache_way.sv
hw/banked_memory.sv
hw/cache_controller.sv
hw/mem_system.sv
bench/clock_gen.sv
bench/tb_mem_system.sv
